//--- roic_readout.f
+incdir+verilog
verilog/roic_readout_pkg.sv
verilog/readout_ctrl.sv
verilog/channel_sequencer.sv
verilog/channel_data_mux.sv
verilog/roic_readout_top.sv
tests/roic_readout_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the roic_readout testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing --assert --top-module roic_readout_tb \
    -f roic_readout.f -o roic_readout_sim > build.log 2>&1 \
    && ./obj_dir/roic_readout_sim > sim.log 2>&1 \
    || { echo "Build or simulation run failed"; cat build.log sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -q "^STATUS: PASS$" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

//--- tests/roic_readout_tb.sv
`timescale 1ns/1ps
`include "roic_readout_defines.svh"

module roic_readout_tb;

    localparam int LINE_WORDS   = `ROIC_NUM_CH * `ROIC_WORDS_PER_CH;
    // Four frame tests of up to 3 lines each at 4 cycles per word
    localparam int WATCHDOG_CYC = 4 * 3 * LINE_WORDS * 4 + 1000;

    logic                         eim_clk;
    logic                         eim_rst;
    logic                         read_start;
    logic                         dummy_get_image;
    logic [`LINE_CNT_W-1:0]       lines_per_frame;
    logic                         tready;
    roic_readout_pkg::roic_word_t roic_data_a [`ROIC_NUM_CH] = '{default: '0};
    roic_readout_pkg::roic_word_t roic_data_b [`ROIC_NUM_CH] = '{default: '0};
    logic [`ROIC_NUM_CH-1:0]      data_req;
    logic                         data_valid;
    roic_readout_pkg::roic_word_t data_out_a;
    roic_readout_pkg::roic_word_t data_out_b;
    logic                         frame_start;
    logic                         tlast;
    logic                         exist_get_image;

    // Memory read counters and the model's own copy
    logic [15:0] rd_cnt [`ROIC_NUM_CH] = '{default: '0};
    int          exp_cnt [`ROIC_NUM_CH] = '{default: 0};
    // Expected word packs frame_start, tlast, A and B
    logic [2*`ROIC_DATA_W+1:0] exp_q [$];
    int    seed = 32'hb9c1_18a7;
    string cur_test = "reset_state";
    bit    dummy_mode;
    int    rx_cnt;
    int    test_err;
    int    err_cnt;
    int    test_cnt;
    int    fail_cnt;

    roic_readout_top uut (
        .eim_clk(eim_clk), .eim_rst(eim_rst), .read_start(read_start),
        .dummy_get_image(dummy_get_image), .lines_per_frame(lines_per_frame),
        .tready(tready), .roic_data_a(roic_data_a), .roic_data_b(roic_data_b),
        .data_req(data_req), .data_valid(data_valid), .data_out_a(data_out_a),
        .data_out_b(data_out_b), .frame_start(frame_start), .tlast(tlast),
        .exist_get_image(exist_get_image)
    );

    initial begin
        eim_clk = 1'b0;
        forever #4 eim_clk = ~eim_clk;
    end

    // ==================================================
    // Channel memory model
    // ==================================================

    // Next word of channel i one cycle after its request
    always @(posedge eim_clk) begin
        for (int i = 0; i < `ROIC_NUM_CH; i++) begin
            if (data_req[i]) begin
                roic_data_a[i] <= roic_readout_pkg::roic_word_t'(i * 65536 + 32'(rd_cnt[i]));
                roic_data_b[i] <= ~roic_readout_pkg::roic_word_t'(i * 65536 + 32'(rd_cnt[i]));
                rd_cnt[i]      <= rd_cnt[i] + 16'd1;
            end
        end
    end

    // ==================================================
    // Output monitor
    // ==================================================

    always @(posedge eim_clk) begin
        logic [2*`ROIC_DATA_W+1:0] exp_w;
        logic [2*`ROIC_DATA_W+1:0] act_w;
        if (!eim_rst) begin
            assert ($onehot0(data_req) && (tready || data_req == '0)) else begin
                $display("%s: bad data_req %b with tready %b", cur_test, data_req, tready);
                test_err++;
            end
            // Sensor flush never touches the memories
            assert (!dummy_mode || data_req == '0) else begin
                $display("%s: data_req %b raised in a dummy frame", cur_test, data_req);
                test_err++;
            end
            if (data_valid) begin
                act_w = {frame_start, tlast, data_out_a, data_out_b};
                assert (exp_q.size() != 0) else begin
                    $display("%s: unexpected extra word %h", cur_test, act_w);
                    test_err++;
                end
                if (exp_q.size() != 0) begin
                    exp_w = exp_q.pop_front();
                    assert (act_w == exp_w) else begin
                        $display("ERROR %s: word %0d expected %h actual %h",
                                 cur_test, rx_cnt, exp_w, act_w);
                        test_err++;
                    end
                end
                // Dummy flag high only for a dummy frame
                assert (exist_get_image == dummy_mode) else begin
                    $display("%s: exist_get_image is %b while dummy frame flag is %b",
                             cur_test, exist_get_image, dummy_mode);
                    test_err++;
                end
                rx_cnt++;
            end else begin
                assert (!frame_start && !tlast) else begin
                    $display("%s: frame marker without a valid word", cur_test);
                    test_err++;
                end
            end
        end
    end

    // ==================================================
    // Tests
    // ==================================================

    task automatic finish_test(input string name, input int lines);
        $display("%s: %0d lines, %0d words, %0d errors", name, lines, rx_cnt, test_err);
        test_cnt++;
        err_cnt += test_err;
        if (test_err != 0) fail_cnt++;
    endtask

    task automatic check_reset_state();
        cur_test = "reset_state";
        assert ({data_req, data_valid, frame_start, tlast, exist_get_image} == '0) else begin
            $display("ERROR reset_state: expected 0 actual %h",
                     {data_req, data_valid, frame_start, tlast, exist_get_image});
            test_err++;
        end
        finish_test("reset_state", 0);
    endtask

    task automatic run_frame(input string name, input bit dummy, input int ready_pct,
                             input bit noise);
        int lines;
        int total;
        roic_readout_pkg::roic_word_t a;
        logic fs;
        logic tl;
        cur_test   = name;
        test_err   = 0;
        rx_cnt     = 0;
        dummy_mode = dummy;
        lines      = 1 + int'({$random(seed)} % 3);
        total      = lines * LINE_WORDS;
        // Whole frame predicted in channel order
        for (int l = 0; l < lines; l++) begin
            for (int ch = 0; ch < `ROIC_NUM_CH; ch++) begin
                for (int w = 0; w < `ROIC_WORDS_PER_CH; w++) begin
                    fs = (l == 0 && ch == 0 && w == 0);
                    tl = (l == lines - 1 && ch == `ROIC_NUM_CH - 1 &&
                          w == `ROIC_WORDS_PER_CH - 1);
                    if (dummy) begin
                        exp_q.push_back({fs, tl, 48'h0});
                    end else begin
                        a = roic_readout_pkg::roic_word_t'(ch * 65536 + exp_cnt[ch]);
                        exp_cnt[ch]++;
                        exp_q.push_back({fs, tl, a, ~a});
                    end
                end
            end
        end
        @(negedge eim_clk);
        lines_per_frame = `LINE_CNT_W'(lines);
        if (dummy) dummy_get_image = 1'b1;
        else read_start = 1'b1;
        @(negedge eim_clk);
        read_start = 1'b0;
        // Random stalls and optional stray starts mid-frame
        while (exp_q.size() != 0) begin
            tready = ({$random(seed)} % 100) < ready_pct;
            if (noise) begin
                read_start = ({$random(seed)} % 40) == 0;
                if (({$random(seed)} % 60) == 0) dummy_get_image = !dummy_get_image;
            end
            @(negedge eim_clk);
        end
        read_start      = 1'b0;
        dummy_get_image = 1'b0;
        tready          = 1'b1;
        // Frame gap has a fixed length
        repeat (`VSYNC_GAP + 4) @(negedge eim_clk);
        dummy_mode = 1'b0;
        assert (rx_cnt == total) else begin
            $display("ERROR %s: word count expected %0d actual %0d", name, total, rx_cnt);
            test_err++;
        end
        assert (!exist_get_image) else begin
            $display("%s: exist_get_image still high after the frame gap", name);
            test_err++;
        end
        finish_test(name, lines);
    endtask

    initial begin
        eim_rst         = 1'b1;
        read_start      = 1'b0;
        dummy_get_image = 1'b0;
        lines_per_frame = `LINE_CNT_W'(1);
        tready          = 1'b1;
        repeat (10) @(posedge eim_clk);
        @(negedge eim_clk);
        eim_rst = 1'b0;
        @(negedge eim_clk);
        check_reset_state();
        run_frame("image_order", 1'b0, 100, 1'b0);
        run_frame("backpressure", 1'b0, 70, 1'b0);
        run_frame("dummy_frame", 1'b1, 70, 1'b0);
        run_frame("ignored_starts", 1'b0, 70, 1'b1);
        $display("Tests: %0d, failed: %0d, errors: %0d", test_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // Hang guard
    initial begin
        repeat (WATCHDOG_CYC) @(posedge eim_clk);
        $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYC);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

//--- verilog/channel_data_mux.sv
`timescale 1ns/1ps
`include "roic_readout_defines.svh"

module channel_data_mux (
    input  logic                          eim_clk,
    input  logic                          eim_rst,
    input  logic [`ROIC_NUM_CH-1:0]       ch_sel,
    input  logic                          word_step,
    input  roic_readout_pkg::frame_kind_e frame_kind,
    input  logic                          last_line,
    input  logic                          line_done,
    input  roic_readout_pkg::roic_word_t  roic_data_a [`ROIC_NUM_CH],
    input  roic_readout_pkg::roic_word_t  roic_data_b [`ROIC_NUM_CH],
    output logic [`ROIC_NUM_CH-1:0]       data_req,
    output logic                          data_valid,
    output roic_readout_pkg::roic_word_t  data_out_a,
    output roic_readout_pkg::roic_word_t  data_out_b,
    output logic                          frame_start,
    output logic                          tlast
);

    logic                         s1_valid;
    logic                         s1_last;
    logic                         s1_dummy;
    logic [`ROIC_NUM_CH-1:0]      s1_sel;
    logic                         first_word;
    roic_readout_pkg::roic_word_t sel_a;
    roic_readout_pkg::roic_word_t sel_b;

    // Requests only for image frames, dummy frames leave memories alone
    assign data_req = (word_step && frame_kind == roic_readout_pkg::FRAME_IMAGE) ?
                      ch_sel : '0;

    // ==================================================
    // Stage 1, waits for memory return
    // ==================================================

    always_ff @(posedge eim_clk or posedge eim_rst) begin
        if (eim_rst) begin
            s1_valid <= 1'b0;
            s1_last  <= 1'b0;
        end else begin
            s1_valid <= word_step;
            s1_last  <= line_done && last_line;
        end
    end

    // Channel and kind follow the step
    always_ff @(posedge eim_clk) begin
        s1_sel   <= ch_sel;
        s1_dummy <= (frame_kind == roic_readout_pkg::FRAME_DUMMY);
    end

    // One-hot select of the returned samples
    always_comb begin
        sel_a = '0;
        sel_b = '0;
        for (int i = 0; i < `ROIC_NUM_CH; i++) begin
            if (s1_sel[i]) begin
                sel_a = sel_a | roic_data_a[i];
                sel_b = sel_b | roic_data_b[i];
            end
        end
    end

    // ==================================================
    // Stage 2, output stream
    // ==================================================

    always_ff @(posedge eim_clk or posedge eim_rst) begin
        if (eim_rst) begin
            data_valid  <= 1'b0;
            frame_start <= 1'b0;
            tlast       <= 1'b0;
            first_word  <= 1'b1;
        end else begin
            data_valid  <= s1_valid;
            frame_start <= s1_valid && first_word;
            tlast       <= s1_valid && s1_last;
            // Rearm after the last word of a frame
            if (s1_valid) begin
                first_word <= s1_last;
            end
        end
    end

    // Zero words while flushing the sensor
    always_ff @(posedge eim_clk) begin
        if (s1_valid) begin
            data_out_a <= s1_dummy ? '0 : sel_a;
            data_out_b <= s1_dummy ? '0 : sel_b;
        end
    end

    // Fixed two-cycle latency from step to output
    a_valid_latency: assert property (@(posedge eim_clk) disable iff (eim_rst)
        data_valid |-> $past(word_step, 2));

endmodule

//--- verilog/channel_sequencer.sv
`timescale 1ns/1ps
`include "roic_readout_defines.svh"

module channel_sequencer (
    input  logic                    eim_clk,
    input  logic                    eim_rst,
    input  logic                    line_go,
    input  logic                    tready,
    output logic [`ROIC_NUM_CH-1:0] ch_sel,
    output logic                    word_step,
    output logic                    line_done
);

    logic [`ROIC_WORD_CNT_W-1:0] word_cnt;
    logic                        last_word;

    // ==================================================
    // Step and end-of-line decode
    // ==================================================

    // One word per cycle while a channel is active and the sink is ready
    assign word_step = (|ch_sel) && tready;

    // Final word of the current channel
    assign last_word = (word_cnt == `ROIC_WORD_CNT_W'(`ROIC_WORDS_PER_CH - 1));

    // Final word of channel 11 ends the line
    assign line_done = word_step && last_word && ch_sel[`ROIC_NUM_CH-1];

    // ==================================================
    // Channel walk
    // ==================================================

    always_ff @(posedge eim_clk or posedge eim_rst) begin
        if (eim_rst) begin
            ch_sel   <= '0;
            word_cnt <= '0;
        end else if (line_go) begin
            // Every line starts at channel 0
            ch_sel   <= `ROIC_NUM_CH'(1);
            word_cnt <= '0;
        end else if (word_step) begin
            if (last_word) begin
                word_cnt <= '0;
                // Shift out of the top bit leaves zero after channel 11
                ch_sel   <= ch_sel << 1;
            end else begin
                word_cnt <= word_cnt + 1'b1;
            end
        end
    end

    // At most one channel memory addressed at any time
    a_ch_sel_onehot: assert property (@(posedge eim_clk) disable iff (eim_rst)
        $onehot0(ch_sel));

endmodule

//--- verilog/readout_ctrl.sv
`timescale 1ns/1ps
`include "roic_readout_defines.svh"

module readout_ctrl (
    input  logic                          eim_clk,
    input  logic                          eim_rst,
    input  logic                          read_start,
    input  logic                          dummy_get_image,
    input  logic [`LINE_CNT_W-1:0]        lines_per_frame,
    input  logic                          line_done,
    output logic                          line_go,
    output logic                          last_line,
    output roic_readout_pkg::frame_kind_e frame_kind,
    output logic                          exist_get_image
);

    // Gap timer must hold VSYNC_GAP - 1
    localparam int GAP_W = $clog2(`VSYNC_GAP + 1);

    roic_readout_pkg::frame_state_e state;
    logic [`LINE_CNT_W-1:0]         line_cnt;
    logic [GAP_W-1:0]               gap_cnt;
    logic                           dummy_q;
    logic                           dummy_rise;
    logic                           start_any;

    // ==================================================
    // Start detection
    // ==================================================

    // Dummy request is a level, only its rising edge counts
    always_ff @(posedge eim_clk or posedge eim_rst) begin
        if (eim_rst) begin
            dummy_q <= 1'b0;
        end else begin
            dummy_q <= dummy_get_image;
        end
    end

    assign dummy_rise = dummy_get_image && !dummy_q;
    assign start_any  = read_start || dummy_rise;

    // Final line of the frame, lines_per_frame is at least 1
    assign last_line = (state == roic_readout_pkg::FS_LINE) &&
                       (line_cnt == lines_per_frame - 1'b1);

    // ==================================================
    // Frame FSM, line counter, gap timer
    // ==================================================

    always_ff @(posedge eim_clk or posedge eim_rst) begin
        if (eim_rst) begin
            state           <= roic_readout_pkg::FS_IDLE;
            line_cnt        <= '0;
            gap_cnt         <= '0;
            line_go         <= 1'b0;
            frame_kind      <= roic_readout_pkg::FRAME_IMAGE;
            exist_get_image <= 1'b0;
        end else begin
            // Single-cycle pulse by default
            line_go <= 1'b0;
            case (state)
                roic_readout_pkg::FS_IDLE: begin
                    if (start_any) begin
                        state    <= roic_readout_pkg::FS_LINE;
                        line_go  <= 1'b1;
                        line_cnt <= '0;
                        // Image start wins over a dummy edge in the same cycle
                        if (read_start) begin
                            frame_kind      <= roic_readout_pkg::FRAME_IMAGE;
                            exist_get_image <= 1'b0;
                        end else begin
                            frame_kind      <= roic_readout_pkg::FRAME_DUMMY;
                            exist_get_image <= 1'b1;
                        end
                    end
                end
                roic_readout_pkg::FS_LINE: begin
                    if (line_done) begin
                        if (last_line) begin
                            state   <= roic_readout_pkg::FS_FRAME_GAP;
                            gap_cnt <= GAP_W'(`VSYNC_GAP - 1);
                        end else begin
                            state    <= roic_readout_pkg::FS_LINE_GAP;
                            gap_cnt  <= GAP_W'(`HSYNC_GAP - 1);
                            line_cnt <= line_cnt + 1'b1;
                        end
                    end
                end
                roic_readout_pkg::FS_LINE_GAP: begin
                    // Counts HSYNC_GAP cycles down to zero, then next line
                    if (gap_cnt == '0) begin
                        state   <= roic_readout_pkg::FS_LINE;
                        line_go <= 1'b1;
                    end else begin
                        gap_cnt <= gap_cnt - 1'b1;
                    end
                end
                default: begin
                    // Frame gap, dummy flag drops with the return to idle
                    if (gap_cnt == '0) begin
                        state           <= roic_readout_pkg::FS_IDLE;
                        exist_get_image <= 1'b0;
                    end else begin
                        gap_cnt <= gap_cnt - 1'b1;
                    end
                end
            endcase
        end
    end

    // Line start only follows an idle start or a finished line gap
    a_line_go_src: assert property (@(posedge eim_clk) disable iff (eim_rst)
        line_go |-> ($past(state) == roic_readout_pkg::FS_IDLE) ||
                    ($past(state) == roic_readout_pkg::FS_LINE_GAP && $past(gap_cnt) == '0));

    // Dummy flag never outlives its frame
    a_exist_idle: assert property (@(posedge eim_clk) disable iff (eim_rst)
        (state == roic_readout_pkg::FS_IDLE) |-> !exist_get_image);

endmodule

//--- verilog/roic_readout_defines.svh
`ifndef ROIC_READOUT_DEFINES_SVH
`define ROIC_READOUT_DEFINES_SVH

// ==================================================
// ROIC geometry
// ==================================================

// Channels read per line, in order 0 to 11
`define ROIC_NUM_CH        12
// Words taken from each channel per line
`define ROIC_WORDS_PER_CH  128
// Word counter width, covers 0..127
`define ROIC_WORD_CNT_W    7
// One sample on the A or B bus
`define ROIC_DATA_W        24

// ==================================================
// Frame timing
// ==================================================

// Line count and lines_per_frame width
`define LINE_CNT_W         16
// Idle cycles between lines
`define HSYNC_GAP          6
// Idle cycles after the last line of a frame
`define VSYNC_GAP          16

`endif

//--- verilog/roic_readout_pkg.sv
`include "roic_readout_defines.svh"

package roic_readout_pkg;

    // Frame sequencer states
    typedef enum logic [1:0] {
        FS_IDLE      = 2'd0,
        FS_LINE      = 2'd1,
        FS_LINE_GAP  = 2'd2,
        FS_FRAME_GAP = 2'd3
    } frame_state_e;

    // Frame opcode, latched on each accepted start
    typedef enum logic {
        FRAME_IMAGE = 1'b0,
        FRAME_DUMMY = 1'b1
    } frame_kind_e;

    // One ROIC sample
    typedef logic [`ROIC_DATA_W-1:0] roic_word_t;

endpackage

//--- verilog/roic_readout_top.sv
`timescale 1ns/1ps
`include "roic_readout_defines.svh"

module roic_readout_top (
    input  logic                         eim_clk,
    input  logic                         eim_rst,
    input  logic                         read_start,
    input  logic                         dummy_get_image,
    input  logic [`LINE_CNT_W-1:0]       lines_per_frame,
    input  logic                         tready,
    input  roic_readout_pkg::roic_word_t roic_data_a [`ROIC_NUM_CH],
    input  roic_readout_pkg::roic_word_t roic_data_b [`ROIC_NUM_CH],
    output logic [`ROIC_NUM_CH-1:0]      data_req,
    output logic                         data_valid,
    output roic_readout_pkg::roic_word_t data_out_a,
    output roic_readout_pkg::roic_word_t data_out_b,
    output logic                         frame_start,
    output logic                         tlast,
    output logic                         exist_get_image
);

    // Control to datapath
    logic                          line_go;
    logic                          last_line;
    roic_readout_pkg::frame_kind_e frame_kind;

    // Sequencer to control and mux
    logic                          line_done;
    logic                          word_step;
    logic [`ROIC_NUM_CH-1:0]       ch_sel;

    // ==================================================
    // Frame control
    // ==================================================

    readout_ctrl u_ctrl (
        .eim_clk         (eim_clk),
        .eim_rst         (eim_rst),
        .read_start      (read_start),
        .dummy_get_image (dummy_get_image),
        .lines_per_frame (lines_per_frame),
        .line_done       (line_done),
        .line_go         (line_go),
        .last_line       (last_line),
        .frame_kind      (frame_kind),
        .exist_get_image (exist_get_image)
    );

    // Channel walk within a line
    channel_sequencer u_seq (
        .eim_clk   (eim_clk),
        .eim_rst   (eim_rst),
        .line_go   (line_go),
        .tready    (tready),
        .ch_sel    (ch_sel),
        .word_step (word_step),
        .line_done (line_done)
    );

    // ==================================================
    // Request gating and output stream
    // ==================================================

    channel_data_mux u_mux (
        .eim_clk     (eim_clk),
        .eim_rst     (eim_rst),
        .ch_sel      (ch_sel),
        .word_step   (word_step),
        .frame_kind  (frame_kind),
        .last_line   (last_line),
        .line_done   (line_done),
        .roic_data_a (roic_data_a),
        .roic_data_b (roic_data_b),
        .data_req    (data_req),
        .data_valid  (data_valid),
        .data_out_a  (data_out_a),
        .data_out_b  (data_out_b),
        .frame_start (frame_start),
        .tlast       (tlast)
    );

endmodule
